//--- logic/aes_apb_front.sv
/*
 * APB slave of the lookup engine.
 * DATA is write-only and STATUS is read-only; anything else ends with pslverr.
 * A DATA write waits while the request FIFO is full.
 * STATUS holds the count in the low bits, empty at bit 8 and full at bit 9.
 */
`timescale 1ns/1ns
`default_nettype none

`include "aes_lookup_defines.svh"

module aes_apb_front (
    input  wire                            clk,
    input  wire                            rst,
    input  wire aes_lookup_pkg::apb_req_t  apb,
    output aes_lookup_pkg::apb_rsp_t       apb_rsp,
    output logic                           push,
    output aes_lookup_pkg::word_t          push_data,
    input  wire                            full,
    input  wire aes_lookup_pkg::fifo_cnt_t count
);

    logic                  access;
    logic                  wr_sel;
    logic                  rd_sel;
    aes_lookup_pkg::word_t status;

    assign access = apb.psel && apb.penable;

    // The address is decoded in the setup phase and used in the access phase.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_sel <= 1'b0;
            rd_sel <= 1'b0;
        end else if (apb.psel && !apb.penable) begin
            wr_sel <= apb.pwrite && (apb.paddr == `AES_REG_DATA);
            rd_sel <= !apb.pwrite && (apb.paddr == `AES_REG_STATUS);
        end
    end

    always_comb begin
        status                        = '0;
        status[`AES_FIFO_CNT_W-1:0]   = count;
        status[8]                     = (count == '0);
        status[9]                     = full;
    end

    always_comb begin
        apb_rsp.prdata  = rd_sel ? status : '0;
        apb_rsp.pready  = access && (!wr_sel || !full);  // Wait states only on a full FIFO.
        apb_rsp.pslverr = access && !wr_sel && !rd_sel;
    end

    assign push      = access && wr_sel && !full;
    assign push_data = apb.pwdata;

endmodule

`default_nettype wire

//--- logic/aes_lookup_defines.svh
/*
 * Constants for the AES lookup engine.
 * Register addresses are byte addresses on a 4-bit APB address bus.
 * AES_FIFO_DEPTH must be a power of two, and AES_FIFO_CNT_W must hold the value
 * AES_FIFO_DEPTH itself.
 */
`ifndef AES_LOOKUP_DEFINES_SVH
`define AES_LOOKUP_DEFINES_SVH

`define AES_APB_ADDR_W 4
`define AES_REG_DATA   4'h0
`define AES_REG_STATUS 4'h4

`define AES_FIFO_DEPTH 4
`define AES_FIFO_CNT_W 3

`endif

//--- logic/aes_lookup_pkg.sv
/*
 * Shared types of the AES lookup engine.
 * Field widths follow the macros in aes_lookup_defines.svh.
 * Column byte 0 is the most significant byte of a word.
 */
`default_nettype none

`include "aes_lookup_defines.svh"

package aes_lookup_pkg;

    typedef logic [7:0]                   byte_t;
    typedef logic [31:0]                  word_t;
    typedef logic [`AES_FIFO_CNT_W-1:0]   fifo_cnt_t;

    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`AES_APB_ADDR_W-1:0] paddr;
        word_t                      pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        byte_t s;   // S-box byte.
        byte_t s2;  // S-box byte times x in GF(2^8).
    } sbox_pair_t;

    typedef struct packed {
        word_t sub_word;
        word_t t0;
        word_t t1;
        word_t t2;
        word_t t3;
    } lookup_res_t;

endpackage

`default_nettype wire

//--- logic/aes_lookup_top.sv
/*
 * AES byte-substitution lookup engine.
 * Columns written over APB come out on the valid/ready result port in
 * write order, three cycles after the write when the pipeline is idle.
 */
`timescale 1ns/1ns
`default_nettype none

module aes_lookup_top (
    input  wire                           clk,
    input  wire                           rst,
    input  wire aes_lookup_pkg::apb_req_t apb,
    output aes_lookup_pkg::apb_rsp_t      apb_rsp,
    output aes_lookup_pkg::lookup_res_t   res,
    output logic                          res_valid,
    input  wire                           res_ready
);

    logic                      push;
    aes_lookup_pkg::word_t     push_data;
    logic                      full;
    logic                      empty;
    aes_lookup_pkg::fifo_cnt_t count;
    logic                      pop;
    aes_lookup_pkg::word_t     pop_data;

    aes_apb_front u_front (
        .clk       (clk),
        .rst       (rst),
        .apb       (apb),
        .apb_rsp   (apb_rsp),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .count     (count)
    );

    aes_req_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .full      (full),
        .count     (count)
    );

    aes_lookup_unit u_lookup (
        .clk       (clk),
        .rst       (rst),
        .pop_data  (pop_data),
        .empty     (empty),
        .pop       (pop),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

endmodule

`default_nettype wire

//--- logic/aes_lookup_unit.sv
/*
 * Two-stage S-box lookup pipeline.
 * Stage one is the ROM register and stage two the result register.
 * A popped column reaches res_valid two cycles later; res holds while
 * res_valid is high and res_ready is low.
 */
`timescale 1ns/1ns
`default_nettype none

module aes_lookup_unit (
    input  wire                          clk,
    input  wire                          rst,
    input  wire aes_lookup_pkg::word_t   pop_data,
    input  wire                          empty,
    output logic                         pop,
    output aes_lookup_pkg::lookup_res_t  res,
    output logic                         res_valid,
    input  wire                          res_ready
);

    aes_lookup_pkg::sbox_pair_t pair [4];
    aes_lookup_pkg::word_t      tw   [4];
    logic                       s1_valid;
    logic                       out_free;
    logic                       s1_ready;

    assign out_free = !res_valid || res_ready;     // Result register can take a new word.
    assign s1_ready = !s1_valid || out_free;
    assign pop      = !empty && s1_ready;

    // Byte i sits at bits 31-8i down to 24-8i of the column.
    for (genvar i = 0; i < 4; i++) begin : g_byte
        aes_sbox_rom u_rom (
            .clk  (clk),
            .rst  (rst),
            .en   (pop),
            .addr (pop_data[31 - 8*i -: 8]),
            .data (pair[i])
        );

        // T word from the high byte down: s, s, 3*s, 2*s.
        assign tw[i] = {pair[i].s, pair[i].s, pair[i].s ^ pair[i].s2, pair[i].s2};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= pop;
            end
            if (out_free) begin
                res_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free && s1_valid) begin
            res.sub_word <= {pair[0].s, pair[1].s, pair[2].s, pair[3].s};
            res.t0       <= {tw[0][7:0],  tw[0][31:8]};   // Rotated right by one byte.
            res.t1       <= {tw[1][15:0], tw[1][31:16]};
            res.t2       <= {tw[2][23:0], tw[2][31:24]};
            res.t3       <= tw[3];
        end
    end

endmodule

`default_nettype wire

//--- logic/aes_req_fifo.sv
/*
 * Synchronous request FIFO of state columns.
 * pop_data shows the head word and is valid while empty is low.
 * A push while full or a pop while empty is ignored.
 */
`timescale 1ns/1ns
`default_nettype none

`include "aes_lookup_defines.svh"

module aes_req_fifo (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            push,
    input  wire aes_lookup_pkg::word_t     push_data,
    input  wire                            pop,
    output aes_lookup_pkg::word_t          pop_data,
    output logic                           empty,
    output logic                           full,
    output aes_lookup_pkg::fifo_cnt_t      count
);

    localparam int PTR_W = $clog2(`AES_FIFO_DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`AES_FIFO_DEPTH - 1);
    localparam aes_lookup_pkg::fifo_cnt_t FULL_CNT = `AES_FIFO_DEPTH;

    aes_lookup_pkg::word_t mem [`AES_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign empty    = (count == '0);
    assign full     = (count == FULL_CNT);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither leave the count alone.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/aes_sbox_rom.sv
/*
 * Registered ROM for the AES S-box and the S-box times x.
 * The output changes only on a cycle with en high and holds otherwise.
 */
`timescale 1ns/1ns
`default_nettype none

module aes_sbox_rom (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       en,
    input  wire aes_lookup_pkg::byte_t addr,
    output aes_lookup_pkg::sbox_pair_t data
);

    // Entry 0 is the leftmost byte of each table.
    localparam logic [2047:0] SBOX = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    localparam logic [2047:0] SBOX_X2 = {
        128'hc6f8eef6_ffd6de91_6002ce56_e7b54dec,
        128'h8f1f89fa_efb28efb_41b35f45_2353e49b,
        128'h75e13d4c_6c7ef583_6851d1f9_e2ab622a,
        128'h0895469d_30370a2f_0e241bdf_cd4e7fea,
        128'h121d5834_36dcb45b_a476b77d_52dd5e13,
        128'ha6b900c1_40e379b6_d48d6772_9498b085,
        128'hbbc54fed_869a6611_8ae904fe_a078254b,
        128'ha25d8005_3f2170f1_6377af42_20e5fdbf,
        128'h811826c3_be35882e_9355fc7a_c8ba32e6,
        128'hc0199ea3_44543b0b_8cc76b28_a7bc16ad,
        128'hdb647414_920c48b8_9fbd43c4_3931d3f2,
        128'hd58b6eda_01b19c49_d8acf3cf_caf44710,
        128'h6ff04a5c_38577397_cba1e83e_96610d0f,
        128'he07c71cc_9006f71c_c26aae69_17993a27,
        128'hd9eb2b22_d2a90733_2d3c15c9_87aa50a5,
        128'h0359091a_65d784d0_82295a1e_7ba86d2c
    };

    logic [10:0] bit_idx;

    assign bit_idx = {~addr, 3'b000};  // Bit offset of entry addr, counted from the right.

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;
        end else if (en) begin
            data.s  <= SBOX[bit_idx +: 8];
            data.s2 <= SBOX_X2[bit_idx +: 8];
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
+incdir+verif
logic/aes_lookup_pkg.sv
logic/aes_sbox_rom.sv
logic/aes_apb_front.sv
logic/aes_req_fifo.sv
logic/aes_lookup_unit.sv
logic/aes_lookup_top.sv
verif/aes_lookup_tb.sv

//--- verif/aes_tb_model.svh
/*
 * Reference model of the lookup engine for the testbench.
 * The S-box comes from the inverse in GF(2^8) and the affine map.
 * Included inside the testbench module.
 */
`ifndef AES_TB_MODEL_SVH
`define AES_TB_MODEL_SVH

function automatic aes_lookup_pkg::byte_t times_x(input aes_lookup_pkg::byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);  // Reduction by x^8 + x^4 + x^3 + x + 1.
endfunction

function automatic aes_lookup_pkg::byte_t gf_multiply(input aes_lookup_pkg::byte_t a,
                                                      input aes_lookup_pkg::byte_t b);
    aes_lookup_pkg::byte_t acc;
    aes_lookup_pkg::byte_t x;
    aes_lookup_pkg::byte_t y;
    acc = 8'h00;
    x   = a;
    y   = b;
    for (int i = 0; i < 8; i++) begin
        if (y[0]) begin
            acc = acc ^ x;
        end
        x = times_x(x);
        y = y >> 1;
    end
    return acc;
endfunction

function automatic aes_lookup_pkg::byte_t byte_inverse(input aes_lookup_pkg::byte_t b);
    if (b == 8'h00) begin
        return 8'h00;  // Zero maps to zero by convention.
    end
    for (int c = 1; c < 256; c++) begin
        if (gf_multiply(b, aes_lookup_pkg::byte_t'(c)) == 8'h01) begin
            return aes_lookup_pkg::byte_t'(c);
        end
    end
    return 8'h00;
endfunction

function automatic aes_lookup_pkg::byte_t rotate_byte_left(input aes_lookup_pkg::byte_t v,
                                                           input int n);
    return (v << n) | (v >> (8 - n));
endfunction

function automatic aes_lookup_pkg::byte_t sbox_value(input aes_lookup_pkg::byte_t b);
    aes_lookup_pkg::byte_t inv;
    inv = byte_inverse(b);
    return inv ^ rotate_byte_left(inv, 1) ^ rotate_byte_left(inv, 2)
               ^ rotate_byte_left(inv, 3) ^ rotate_byte_left(inv, 4) ^ 8'h63;
endfunction

function automatic aes_lookup_pkg::word_t rotate_word_right(input aes_lookup_pkg::word_t w,
                                                            input int n);
    return (w >> n) | (w << (32 - n));
endfunction

function automatic aes_lookup_pkg::word_t t_word(input aes_lookup_pkg::byte_t b);
    aes_lookup_pkg::byte_t s;
    aes_lookup_pkg::byte_t s2;
    s  = sbox_value(b);
    s2 = times_x(s);
    return {s, s, s2 ^ s, s2};
endfunction

function automatic aes_lookup_pkg::lookup_res_t expected_result(input aes_lookup_pkg::word_t col);
    aes_lookup_pkg::lookup_res_t r;
    r.sub_word = {sbox_value(col[31:24]), sbox_value(col[23:16]),
                  sbox_value(col[15:8]), sbox_value(col[7:0])};
    r.t0 = rotate_word_right(t_word(col[31:24]), 8);
    r.t1 = rotate_word_right(t_word(col[23:16]), 16);
    r.t2 = rotate_word_right(t_word(col[15:8]), 24);
    r.t3 = t_word(col[7:0]);
    return r;
endfunction

// Status register layout: count in the low bits, empty at bit 8, full at bit 9.
function automatic aes_lookup_pkg::word_t status_word(input int cnt, input logic is_empty,
                                                      input logic is_full);
    aes_lookup_pkg::word_t w;
    w    = 32'h0;
    w    = w | cnt;
    w[8] = is_empty;
    w[9] = is_full;
    return w;
endfunction

`endif

//--- verif/aes_lookup_tb.sv
/*
 * Testbench of the AES lookup engine.
 * Columns from a table go in over APB and each result is checked against
 * the model in write order. The first error ends the run.
 */
`timescale 1ns/1ns
`default_nettype none

`include "aes_lookup_defines.svh"

module aes_lookup_tb;

    localparam int NUM_FIXED      = 5;
    localparam int NUM_RANDOM     = 8;
    localparam int NUM_ENTRIES    = NUM_FIXED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 300;
    localparam int HELD_WRITES    = `AES_FIFO_DEPTH + 2;

    logic                        clk;
    logic                        rst;
    aes_lookup_pkg::apb_req_t    apb_req;
    aes_lookup_pkg::apb_rsp_t    apb_rsp;
    aes_lookup_pkg::lookup_res_t res;
    logic                        res_valid;
    logic                        res_ready;

    aes_lookup_pkg::word_t       col_tab [NUM_ENTRIES];
    aes_lookup_pkg::lookup_res_t exp_tab [NUM_ENTRIES];
    aes_lookup_pkg::lookup_res_t exp_q [$];
    aes_lookup_pkg::lookup_res_t exp_head;
    aes_lookup_pkg::lookup_res_t held_res;
    logic                        held;
    int                          results_seen;
    int                          cycle_count;
    integer                      seed;

    `include "aes_tb_model.svh"

    aes_lookup_top dut (
        .clk       (clk),
        .rst       (rst),
        .apb       (apb_req),
        .apb_rsp   (apb_rsp),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input aes_lookup_pkg::word_t got,
                              input aes_lookup_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_on_error("A value did not match.");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_on_error("A flag did not match.");
        end
    endtask

    task automatic check_res(input string name, input aes_lookup_pkg::lookup_res_t got,
                             input aes_lookup_pkg::lookup_res_t exp);
        check_word({name, ".sub_word"}, got.sub_word, exp.sub_word);
        check_word({name, ".t0"}, got.t0, exp.t0);
        check_word({name, ".t1"}, got.t1, exp.t1);
        check_word({name, ".t2"}, got.t2, exp.t2);
        check_word({name, ".t3"}, got.t3, exp.t3);
    endtask

    // Called just after a rising edge; leaves the bus in the access phase.
    task automatic start_transfer(input logic write, input logic [`AES_APB_ADDR_W-1:0] addr,
                                  input aes_lookup_pkg::word_t data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
    endtask

    task automatic finish_transfer(output aes_lookup_pkg::word_t rdata, output logic err);
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic write_column(input aes_lookup_pkg::word_t col);
        aes_lookup_pkg::word_t rdata;
        logic                  err;
        start_transfer(1'b1, `AES_REG_DATA, col);
        finish_transfer(rdata, err);
        check_flag("pslverr on DATA write", err, 1'b0);
    endtask

    task automatic read_status(output aes_lookup_pkg::word_t value);
        logic err;
        start_transfer(1'b0, `AES_REG_STATUS, 32'h0);
        finish_transfer(value, err);
        check_flag("pslverr on STATUS read", err, 1'b0);
    endtask

    task automatic wait_for_results(input int target);
        while (results_seen < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Result port monitor; a transfer happens at the next rising edge.
    always @(negedge clk) begin
        if (!rst && res_valid) begin
            if (held) begin
                check_res("res while stalled", res, held_res);
            end
            if (res_ready) begin
                held = 1'b0;
                if (exp_q.size() == 0) begin
                    stop_on_error("A result appeared with no column written for it.");
                end else begin
                    exp_head = exp_q.pop_front();
                    check_res("res", res, exp_head);
                    results_seen++;
                end
            end else begin
                held     = 1'b1;
                held_res = res;
            end
        end else if (held) begin
            stop_on_error("res_valid dropped before the result was taken.");
        end else begin
            held = 1'b0;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        stop_on_error("Timeout: the run did not finish within the cycle limit.");
    end

    initial begin
        aes_lookup_pkg::word_t rdata;
        logic                  err;
        int                    base;

        rst          = 1'b1;
        apb_req      = '0;
        res_ready    = 1'b0;
        held         = 1'b0;
        results_seen = 0;
        seed         = 47904;

        col_tab[0] = 32'h00000000;
        col_tab[1] = 32'h00010253;
        col_tab[2] = 32'hFFFFFFFF;
        col_tab[3] = 32'h01234567;
        col_tab[4] = 32'h8090A0B0;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            col_tab[NUM_FIXED + i] = $random(seed);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            exp_tab[i] = expected_result(col_tab[i]);
        end
        check_word("model sub_word of 00010253", exp_tab[1].sub_word, 32'h637C77ED);

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // After reset.
        @(negedge clk);
        check_flag("res_valid after reset", res_valid, 1'b0);
        @(posedge clk);
        #1;
        read_status(rdata);
        check_word("STATUS after reset", rdata, status_word(0, 1'b1, 1'b0));

        // One column at a time, then the whole table back to back.
        res_ready = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            exp_q.push_back(exp_tab[i]);
            write_column(col_tab[i]);
            wait_for_results(i + 1);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            exp_q.push_back(exp_tab[i]);
            write_column(col_tab[i]);
        end
        wait_for_results(2 * NUM_ENTRIES);

        // Back-pressure with the result port held.
        base      = results_seen;
        res_ready = 1'b0;
        for (int i = 0; i < HELD_WRITES; i++) begin
            exp_q.push_back(exp_tab[i]);
            write_column(col_tab[i]);
        end
        read_status(rdata);
        check_word("STATUS when full", rdata, status_word(`AES_FIFO_DEPTH, 1'b0, 1'b1));
        exp_q.push_back(exp_tab[HELD_WRITES]);
        start_transfer(1'b1, `AES_REG_DATA, col_tab[HELD_WRITES]);
        repeat (8) begin
            @(negedge clk);
            check_flag("pready while FIFO full", apb_rsp.pready, 1'b0);
        end
        @(posedge clk);
        #1;
        res_ready = 1'b1;
        finish_transfer(rdata, err);
        check_flag("pslverr on waited write", err, 1'b0);
        wait_for_results(base + HELD_WRITES + 1);

        // Bad accesses.
        start_transfer(1'b1, 4'h8, 32'hA5A5A5A5);
        finish_transfer(rdata, err);
        check_flag("pslverr on write to 0x8", err, 1'b1);
        start_transfer(1'b0, `AES_REG_DATA, 32'h0);
        finish_transfer(rdata, err);
        check_flag("pslverr on DATA read", err, 1'b1);
        repeat (10) @(posedge clk);
        #1;
        read_status(rdata);
        check_word("STATUS at end", rdata, status_word(0, 1'b1, 1'b0));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
